// File: build.f
+incdir+common
+incdir+verif
common/kbd_types_pkg.sv
common/kbd_map_pkg.sv
common/key_report_if.sv
hw/kbd_frame_rx/kbd_frame_rx.sv
hw/kbd_event_decoder/kbd_event_decoder.sv
hw/key_fifo.sv
hw/kbd_subsystem.sv
verif/tb_kbd_subsystem.sv

// File: common/kbd_config.svh
`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// ------------------------------------------------------------
// Serial line timing
// ------------------------------------------------------------

// Clock cycles per serial bit.
`define KBD_CLKS_PER_BIT 8

// ------------------------------------------------------------
// Typematic repeat, counted in make events of a held key
// ------------------------------------------------------------

// Make events before the first repeat report.
`define KBD_REPEAT_FIRST 4
// Make events between later repeat reports.
`define KBD_REPEAT_NEXT 2

// ------------------------------------------------------------
// Report queue
// ------------------------------------------------------------

`define KBD_FIFO_DEPTH 8

`endif

// File: common/kbd_map_pkg.sv
package kbd_map_pkg;

	import kbd_types_pkg::*;

	localparam int KBD_MATRIX_KEYS = 48;
	localparam int KBD_MATRIX_ROWS = 6;
	localparam int SHIFT_POS = 5; // Both shift keys share this position.

	// ------------------------------------------------------------
	// Scancodes with a special role
	// ------------------------------------------------------------

	localparam scancode_t SC_LSHIFT = 7'h0f;
	localparam scancode_t SC_RSHIFT = 7'h34;
	localparam scancode_t SC_CTRL = 7'h3d;
	localparam scancode_t SC_GRAPH = 7'h3a;
	localparam scancode_t SC_ALPHA = 7'h48;
	localparam scancode_t SC_TURBO = 7'h4e;
	localparam scancode_t SC_TURBO_LOCK = 7'h40;

	typedef struct packed {
		logic valid; // Code has a matrix position.
		logic [5:0] pos;
	} matrix_pos_t;

	// ------------------------------------------------------------
	// Scancode to matrix position
	// ------------------------------------------------------------

	function automatic matrix_pos_t key_matrix_index(scancode_t code);
		matrix_pos_t r;
		r.valid = 1'b1;
		r.pos = 6'd0;
		case (code)
			7'h08: r.pos = 6'd20;
			7'h09: r.pos = 6'd14;
			7'h0a: r.pos = 6'd45;
			7'h0b: r.pos = 6'd28;
			7'h0c: r.pos = 6'd47;
			7'h0d: r.pos = 6'd13;
			7'h0e: r.pos = 6'd22;
			7'h10: r.pos = 6'd36;
			7'h11: r.pos = 6'd30;
			7'h12: r.pos = 6'd21;
			7'h13: r.pos = 6'd35;
			7'h14: r.pos = 6'd23;
			7'h15: r.pos = 6'd29;
			7'h16: r.pos = 6'd38;
			7'h17: r.pos = 6'd15;
			7'h18: r.pos = 6'd27;
			7'h19: r.pos = 6'd34;
			7'h1a: r.pos = 6'd37;
			7'h1b: r.pos = 6'd19;
			7'h1c: r.pos = 6'd39;
			7'h1d: r.pos = 6'd33;
			7'h1e: r.pos = 6'd26;
			7'h1f: r.pos = 6'd31;
			7'h20: r.pos = 6'd11;
			7'h21: r.pos = 6'd18;
			7'h22: r.pos = 6'd25;
			7'h23: r.pos = 6'd43;
			7'h24: r.pos = 6'd24;
			7'h25: r.pos = 6'd17;
			7'h26: r.pos = 6'd10;
			7'h27: r.pos = 6'd32;
			7'h28: r.pos = 6'd0;
			7'h29: r.pos = 6'd42;
			7'h2a: r.pos = 6'd9;
			7'h2c: r.pos = 6'd8;
			7'h2d: r.pos = 6'd41;
			7'h2e: r.pos = 6'd40;
			7'h2f: r.pos = 6'd16;
			7'h38: r.pos = 6'd44;
			7'h3b: r.pos = 6'd12;
			7'h3c: r.pos = 6'd1;
			7'h3e: r.pos = 6'd46;
			7'h4d: r.pos = 6'd2;
			SC_GRAPH: r.pos = 6'd6;
			SC_CTRL: r.pos = 6'd4;
			SC_LSHIFT, SC_RSHIFT: r.pos = 6'(SHIFT_POS);
			default: r.valid = 1'b0; // Not on the matrix.
		endcase
		return r;
	endfunction

endpackage

// File: common/kbd_types_pkg.sv
package kbd_types_pkg;

	// ------------------------------------------------------------
	// Codes
	// ------------------------------------------------------------

	typedef logic [6:0] scancode_t; // Code as sent on the serial line.
	typedef logic [6:0] keycode_t; // Code as handed to the host.

	// ------------------------------------------------------------
	// Modifiers
	// ------------------------------------------------------------

	typedef logic [3:0] modifier_t;

	localparam int MOD_LSHIFT = 3;
	localparam int MOD_RSHIFT = 2;
	localparam int MOD_CTRL = 1;
	localparam int MOD_GRAPH = 0;

	// ------------------------------------------------------------
	// Host side of the emulated matrix
	// ------------------------------------------------------------

	typedef logic [2:0] matrix_row_t; // Row select, eight columns per row.
	typedef logic [7:0] matrix_cols_t;

	// ------------------------------------------------------------
	// Key report
	// ------------------------------------------------------------

	typedef struct packed {
		keycode_t keycode;
		logic isup; // Set for a release.
		modifier_t modifiers; // Modifiers before the event.
	} key_report_t;

endpackage

// File: common/key_report_if.sv
interface key_report_if;

	import kbd_types_pkg::*;

	logic valid; // One-cycle push strobe.
	keycode_t keycode;
	logic isup;
	modifier_t modifiers;

	modport source (
		output valid,
		output keycode,
		output isup,
		output modifiers
	);

	modport sink (
		input valid,
		input keycode,
		input isup,
		input modifiers
	);

endinterface

// File: hw/kbd_event_decoder/kbd_event_decoder.sv
`include "kbd_config.svh"

module kbd_event_decoder (
	input logic clk,
	input logic reset,
	input logic event_strobe,
	input kbd_types_pkg::scancode_t event_code,
	input logic event_pressed,
	input logic keyboard_block,
	input kbd_types_pkg::matrix_row_t matrix_row,
	output kbd_types_pkg::matrix_cols_t matrix_cols,
	output logic alpha_state,
	output logic turbo_state,
	output kbd_types_pkg::modifier_t modifiers,
	key_report_if.source report
);

	import kbd_types_pkg::*;
	import kbd_map_pkg::*;

	localparam int CNT_W = $clog2(`KBD_REPEAT_FIRST + 1);

	logic [KBD_MATRIX_KEYS-1:0] matrix;
	logic [1:0] shift_down; // Left, right.
	logic turbo_lock;
	logic turbo_pulse;
	scancode_t held_code;
	logic held;
	logic [CNT_W-1:0] repeat_cnt;
	matrix_pos_t pos;
	logic is_held;
	logic matrix_write;

	assign pos = key_matrix_index(event_code);
	assign is_held = held && event_code == held_code;
	assign matrix_write = event_strobe && pos.valid && !(event_pressed && keyboard_block);
	assign turbo_state = turbo_lock | turbo_pulse;
	assign matrix_cols = (matrix_row < matrix_row_t'(KBD_MATRIX_ROWS)) ?
		matrix[{matrix_row, 3'b000} +: $bits(matrix_cols_t)] : '0;

	// ------------------------------------------------------------
	// Modifier, alpha and turbo state
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			modifiers <= '0;
			alpha_state <= 1'b0;
			turbo_lock <= 1'b0;
			turbo_pulse <= 1'b0;
		end else if (event_strobe) begin
			case (event_code)
				SC_LSHIFT: modifiers[MOD_LSHIFT] <= event_pressed;
				SC_RSHIFT: modifiers[MOD_RSHIFT] <= event_pressed;
				SC_CTRL: modifiers[MOD_CTRL] <= event_pressed;
				SC_GRAPH: modifiers[MOD_GRAPH] <= event_pressed;
				SC_ALPHA: alpha_state <= event_pressed;
				SC_TURBO: turbo_pulse <= event_pressed; // Held turbo key.
				SC_TURBO_LOCK: begin
					if (event_pressed)
						turbo_lock <= ~turbo_lock;
				end
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------
	// Emulated matrix
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			matrix <= '0;
			shift_down <= '0;
		end else if (matrix_write) begin
			if (event_code == SC_LSHIFT) begin
				shift_down[1] <= event_pressed;
				matrix[SHIFT_POS] <= event_pressed | shift_down[0];
			end else if (event_code == SC_RSHIFT) begin
				shift_down[0] <= event_pressed;
				matrix[SHIFT_POS] <= event_pressed | shift_down[1];
			end else begin
				matrix[pos.pos] <= event_pressed;
			end
		end
	end

	// ------------------------------------------------------------
	// Key reports with typematic repeat
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			report.valid <= 1'b0;
			held <= 1'b0;
			held_code <= '0;
			repeat_cnt <= '0;
		end else begin
			report.valid <= 1'b0;
			if (event_strobe && event_pressed && !is_held) begin
				report.valid <= 1'b1; // New press.
				held <= 1'b1;
				held_code <= event_code;
				repeat_cnt <= CNT_W'(`KBD_REPEAT_FIRST);
			end else if (event_strobe && event_pressed) begin
				if (repeat_cnt == CNT_W'(1)) begin
					report.valid <= 1'b1;
					repeat_cnt <= CNT_W'(`KBD_REPEAT_NEXT);
				end else begin
					repeat_cnt <= repeat_cnt - 1'b1;
				end
			end else if (event_strobe && is_held) begin
				report.valid <= 1'b1; // Release of the held key.
				held <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (event_strobe) begin
			report.keycode <= event_code;
			report.isup <= ~event_pressed;
			report.modifiers <= modifiers;
		end
	end

	row_in_range: assert property (@(posedge clk) disable iff (reset)
		matrix_row < matrix_row_t'(KBD_MATRIX_ROWS));

endmodule

// File: hw/kbd_frame_rx/kbd_frame_rx.sv
`include "kbd_config.svh"

module kbd_frame_rx (
	input logic clk,
	input logic reset,
	input logic rx_line,
	output logic event_strobe,
	output kbd_types_pkg::scancode_t event_code,
	output logic event_pressed
);

	localparam int FRAME_BITS = 10; // Start, seven code bits, release, stop.
	localparam int PHASE_W = $clog2(`KBD_CLKS_PER_BIT);
	localparam int MID_PHASE = `KBD_CLKS_PER_BIT / 2 - 1;

	logic sync_a;
	logic sync_b;
	logic sync_prev;
	logic busy;
	logic [PHASE_W-1:0] phase;
	logic [3:0] bit_idx;
	logic [7:0] shreg; // Release bit on top of the code.
	logic stop_ok;
	logic start_edge;
	logic mid_bit;
	logic bit_end;
	logic last_cycle;

	assign start_edge = sync_prev & ~sync_b;
	assign mid_bit = busy && phase == PHASE_W'(MID_PHASE);
	assign bit_end = phase == PHASE_W'(`KBD_CLKS_PER_BIT - 1);
	assign last_cycle = busy && bit_end && bit_idx == 4'(FRAME_BITS - 1);

	// ------------------------------------------------------------
	// Synchroniser and bit timing
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_a <= 1'b1;
			sync_b <= 1'b1;
			sync_prev <= 1'b1;
			busy <= 1'b0;
			phase <= '0;
			bit_idx <= '0;
			event_strobe <= 1'b0;
		end else begin
			sync_a <= rx_line;
			sync_b <= sync_a;
			sync_prev <= sync_b;
			event_strobe <= last_cycle & stop_ok;
			if (!busy || last_cycle) begin
				busy <= start_edge; // Back-to-back frames restart here.
				phase <= '0;
				bit_idx <= '0;
			end else if (mid_bit && bit_idx == 4'd0 && sync_b) begin
				busy <= 1'b0; // Start bit gone, a glitch.
			end else if (bit_end) begin
				phase <= '0;
				bit_idx <= bit_idx + 4'd1;
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// Shift register and event
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (mid_bit) begin
			if (bit_idx == 4'(FRAME_BITS - 1))
				stop_ok <= sync_b;
			else if (bit_idx != 4'd0)
				shreg <= {sync_b, shreg[7:1]}; // LSB first.
		end
		if (last_cycle) begin
			event_code <= shreg[6:0];
			event_pressed <= ~shreg[7];
		end
	end

	strobe_single: assert property (@(posedge clk) disable iff (reset)
		event_strobe |=> !event_strobe);

endmodule

// File: hw/kbd_subsystem.sv
module kbd_subsystem (
	input logic clk,
	input logic reset,
	input logic rx_line,
	input kbd_types_pkg::matrix_row_t matrix_row,
	input logic pop,
	input logic keyboard_block,
	output kbd_types_pkg::matrix_cols_t matrix_cols,
	output logic alpha_state,
	output logic turbo_state,
	output kbd_types_pkg::modifier_t modifiers,
	output logic report_valid,
	output kbd_types_pkg::keycode_t report_keycode,
	output logic report_isup,
	output kbd_types_pkg::modifier_t report_modifiers,
	output logic overflow
);

	import kbd_types_pkg::*;

	logic event_strobe;
	scancode_t event_code;
	logic event_pressed;
	key_report_t head;

	key_report_if report_bus ();

	kbd_frame_rx u_kbd_frame_rx (
		.clk(clk),
		.reset(reset),
		.rx_line(rx_line),
		.event_strobe(event_strobe),
		.event_code(event_code),
		.event_pressed(event_pressed)
	);

	kbd_event_decoder u_kbd_event_decoder (
		.clk(clk),
		.reset(reset),
		.event_strobe(event_strobe),
		.event_code(event_code),
		.event_pressed(event_pressed),
		.keyboard_block(keyboard_block),
		.matrix_row(matrix_row),
		.matrix_cols(matrix_cols),
		.alpha_state(alpha_state),
		.turbo_state(turbo_state),
		.modifiers(modifiers),
		.report(report_bus.source)
	);

	key_fifo #(
		.T(key_report_t)
	) u_key_fifo (
		.clk(clk),
		.reset(reset),
		.in(report_bus.sink),
		.pop(pop),
		.head(head),
		.not_empty(report_valid),
		.overflow(overflow)
	);

	assign report_keycode = head.keycode;
	assign report_isup = head.isup;
	assign report_modifiers = head.modifiers;

endmodule

// File: hw/key_fifo.sv
`include "kbd_config.svh"

module key_fifo #(
	parameter type T = kbd_types_pkg::key_report_t
) (
	input logic clk,
	input logic reset,
	key_report_if.sink in,
	input logic pop,
	output T head,
	output logic not_empty,
	output logic overflow
);

	localparam int DEPTH = `KBD_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	T wdata;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign wdata = {in.keycode, in.isup, in.modifiers};
	assign full = count == CNT_W'(DEPTH);
	assign not_empty = count != '0;
	assign do_push = in.valid && !full;
	assign do_pop = pop && not_empty; // Pop on empty is ignored.
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			if (in.valid && full)
				overflow <= 1'b1; // Sticky, report dropped.
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= CNT_W'(DEPTH));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the keyboard subsystem testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")"

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f build.f --top-module tb_kbd_subsystem \
	-Mdir "$OBJ_DIR" -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

"./$OBJ_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

# The log decides pass or fail.
if grep -qx "RESULT: PASS" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG."
exit 1

// File: verif/kbd_tests.svh
`ifndef KBD_TESTS_SVH
`define KBD_TESTS_SVH

// ------------------------------------------------------------
// Single keys through matrix and FIFO
// ------------------------------------------------------------

task automatic press_release_keys();
	int idx;
	for (int n = 0; n < 5; n++) begin
		pick_key(idx);
		send_frame(KEY_CODE[idx], 1'b1);
		check_key(idx, 1'b1, "key pressed");
		expect_report(KEY_CODE[idx], 1'b0, '0, "press report");
		send_frame(KEY_CODE[idx], 1'b0);
		check_key(idx, 1'b0, "key released");
		expect_report(KEY_CODE[idx], 1'b1, '0, "release report");
	end
endtask

task automatic shift_pairing();
	send_frame(SC_LSHIFT, 1'b1);
	check_mods(modifiers, 4'b1000, "left shift down");
	expect_report(SC_LSHIFT, 1'b0, 4'b0000, "left shift press");
	send_frame(SC_RSHIFT, 1'b1);
	check_mods(modifiers, 4'b1100, "both shifts down");
	check_row(3'd0, 8'h20, "both shifts in matrix");
	expect_report(SC_RSHIFT, 1'b0, 4'b1000, "right shift press");
	send_frame(SC_LSHIFT, 1'b0);
	check_mods(modifiers, 4'b0100, "left shift up");
	check_row(3'd0, 8'h20, "right shift keeps position");
	expect_no_report("left shift release");
	send_frame(SC_RSHIFT, 1'b0);
	check_mods(modifiers, 4'b0000, "both shifts up");
	check_row(3'd0, 8'h00, "shift position cleared");
	expect_report(SC_RSHIFT, 1'b1, 4'b0100, "right shift release");
endtask

task automatic block_input();
	@(posedge clk);
	keyboard_block <= 1'b1;
	send_frame(KEY_CODE[3], 1'b1);
	check_key(3, 1'b0, "blocked press leaves matrix");
	expect_report(KEY_CODE[3], 1'b0, '0, "blocked press report");
	send_frame(KEY_CODE[3], 1'b0);
	expect_report(KEY_CODE[3], 1'b1, '0, "blocked release report");
	@(posedge clk);
	keyboard_block <= 1'b0;
	send_frame(KEY_CODE[3], 1'b1);
	check_key(3, 1'b1, "unblocked press");
	expect_report(KEY_CODE[3], 1'b0, '0, "unblocked press report");
	send_frame(KEY_CODE[3], 1'b0);
	check_key(3, 1'b0, "unblocked release");
	expect_report(KEY_CODE[3], 1'b1, '0, "unblocked release report");
endtask

// ------------------------------------------------------------
// Typematic repeat
// ------------------------------------------------------------

task automatic typematic_repeat();
	for (int n = 1; n <= 9; n++) begin
		send_frame(KEY_CODE[0], 1'b1);
		if (n == 1 || n == 5 || n == 7 || n == 9)
			expect_report(KEY_CODE[0], 1'b0, '0, "typematic report");
		else
			expect_no_report("typematic hold");
	end
	send_frame(KEY_CODE[0], 1'b0);
	expect_report(KEY_CODE[0], 1'b1, '0, "typematic release");
	send_frame(KEY_CODE[0], 1'b1);
	expect_report(KEY_CODE[0], 1'b0, '0, "first key press");
	send_frame(KEY_CODE[0], 1'b1);
	expect_no_report("first key hold");
	send_frame(KEY_CODE[1], 1'b1); // Other key takes over.
	expect_report(KEY_CODE[1], 1'b0, '0, "interleaved key press");
	for (int n = 1; n <= 5; n++) begin
		send_frame(KEY_CODE[0], 1'b1);
		if (n == 1 || n == 5)
			expect_report(KEY_CODE[0], 1'b0, '0, "restarted count report");
		else
			expect_no_report("restarted count hold");
	end
	send_frame(KEY_CODE[0], 1'b0);
	expect_report(KEY_CODE[0], 1'b1, '0, "first key release");
	send_frame(KEY_CODE[1], 1'b0);
	expect_no_report("release of a key no longer held");
	check_key(0, 1'b0, "first key cleared");
	check_key(1, 1'b0, "interleaved key cleared");
endtask

task automatic turbo_and_alpha();
	send_frame(SC_TURBO_LOCK, 1'b1);
	check_level(turbo_state, 1'b1, "turbo lock on");
	expect_report(SC_TURBO_LOCK, 1'b0, '0, "turbo lock press");
	send_frame(SC_TURBO_LOCK, 1'b0);
	check_level(turbo_state, 1'b1, "turbo lock kept after release");
	expect_report(SC_TURBO_LOCK, 1'b1, '0, "turbo lock release");
	send_frame(SC_TURBO_LOCK, 1'b1);
	check_level(turbo_state, 1'b0, "turbo lock off");
	expect_report(SC_TURBO_LOCK, 1'b0, '0, "turbo lock press");
	send_frame(SC_TURBO_LOCK, 1'b0);
	expect_report(SC_TURBO_LOCK, 1'b1, '0, "turbo lock release");
	send_frame(SC_TURBO, 1'b1);
	check_level(turbo_state, 1'b1, "turbo key held");
	expect_report(SC_TURBO, 1'b0, '0, "turbo key press");
	send_frame(SC_TURBO, 1'b0);
	check_level(turbo_state, 1'b0, "turbo key released");
	expect_report(SC_TURBO, 1'b1, '0, "turbo key release");
	send_frame(SC_ALPHA, 1'b1);
	check_level(alpha_state, 1'b1, "alpha held");
	expect_report(SC_ALPHA, 1'b0, '0, "alpha press");
	send_frame(SC_ALPHA, 1'b0);
	check_level(alpha_state, 1'b0, "alpha released");
	expect_report(SC_ALPHA, 1'b1, '0, "alpha release");
endtask

task automatic fifo_overflow();
	for (int n = 0; n < 9; n++) begin
		send_frame(KEY_CODE[n], 1'b1);
		if (n == 7)
			check_level(overflow, 1'b0, "FIFO full without overflow");
	end
	check_level(overflow, 1'b1, "overflow after ninth report");
	for (int n = 0; n < 8; n++)
		expect_report(KEY_CODE[n], 1'b0, '0, "queued report");
	expect_no_report("ninth report dropped");
	check_level(overflow, 1'b1, "overflow stays set");
endtask

`endif

// File: verif/tb_kbd_subsystem.sv
`include "kbd_config.svh"

module tb_kbd_subsystem;

	timeunit 1ns;
	timeprecision 1ps;

	import kbd_types_pkg::*;
	import kbd_map_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int IDLE_BITS = 2; // Line idle after each stop bit.
	localparam int FRAME_CYCLES = (10 + IDLE_BITS) * `KBD_CLKS_PER_BIT;
	localparam int N_FRAMES = 55;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_FRAMES * FRAME_CYCLES * 2;
	localparam int N_KEYS = 16;

	// Ordinary keys and their matrix positions.
	localparam scancode_t KEY_CODE [N_KEYS] = '{7'h08, 7'h09, 7'h0a, 7'h0b, 7'h0c, 7'h0d,
		7'h0e, 7'h10, 7'h11, 7'h12, 7'h13, 7'h14, 7'h28, 7'h2c, 7'h38, 7'h4d};
	localparam int KEY_POS [N_KEYS] = '{20, 14, 45, 28, 47, 13,
		22, 36, 30, 21, 35, 23, 0, 8, 44, 2};

	logic clk;
	logic reset;
	logic rx_line;
	matrix_row_t matrix_row;
	logic pop;
	logic keyboard_block;
	matrix_cols_t matrix_cols;
	logic alpha_state;
	logic turbo_state;
	modifier_t modifiers;
	logic report_valid;
	keycode_t report_keycode;
	logic report_isup;
	modifier_t report_modifiers;
	logic overflow;
	logic [7:0] lfsr;
	int mismatch_count;
	int failure_count;

	kbd_subsystem u_kbd_subsystem (
		.clk(clk),
		.reset(reset),
		.rx_line(rx_line),
		.matrix_row(matrix_row),
		.pop(pop),
		.keyboard_block(keyboard_block),
		.matrix_cols(matrix_cols),
		.alpha_state(alpha_state),
		.turbo_state(turbo_state),
		.modifiers(modifiers),
		.report_valid(report_valid),
		.report_keycode(report_keycode),
		.report_isup(report_isup),
		.report_modifiers(report_modifiers),
		.overflow(overflow)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests finished.");
		$display("RESULT: FAIL");
		$finish;
	end

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------

	function automatic logic [7:0] lfsr_next(logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic pick_key(output int idx);
		idx = 0;
		for (int i = 0; i < 4; i++) begin
			lfsr = lfsr_next(lfsr); // One step per bit.
			idx = (idx << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic send_frame(scancode_t code, logic pressed);
		logic [9:0] frame;
		frame = {1'b1, ~pressed, code, 1'b0}; // Stop, release, code, start.
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rx_line <= frame[i];
			repeat (`KBD_CLKS_PER_BIT - 1) @(posedge clk);
		end
		@(posedge clk);
		rx_line <= 1'b1;
		repeat (IDLE_BITS * `KBD_CLKS_PER_BIT - 1) @(posedge clk);
		@(negedge clk);
	endtask

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------

	task automatic check_report(key_report_t got, key_report_t exp, string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s, report %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_cols(matrix_cols_t got, matrix_cols_t exp, string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s, columns %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_mods(modifier_t got, modifier_t exp, string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s, modifiers %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_level(logic got, logic exp, string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s, level %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ------------------------------------------------------------
	// Host side helpers
	// ------------------------------------------------------------

	task automatic check_row(matrix_row_t row, matrix_cols_t exp, string what);
		@(posedge clk);
		matrix_row <= row;
		@(negedge clk);
		check_cols(matrix_cols, exp, what);
	endtask

	task automatic check_key(int idx, logic pressed, string what);
		matrix_cols_t exp;
		exp = pressed ? matrix_cols_t'(1 << (KEY_POS[idx] % 8)) : '0;
		check_row(matrix_row_t'(KEY_POS[idx] / 8), exp, what);
	endtask

	task automatic expect_report(scancode_t code, logic isup, modifier_t mods, string what);
		key_report_t exp;
		key_report_t got;
		int waited;
		exp.keycode = code;
		exp.isup = isup;
		exp.modifiers = mods;
		waited = 0;
		@(negedge clk);
		while (!report_valid && waited < FRAME_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!report_valid) begin
			failure_count++;
			$display("No key report arrived by %0t for %s.", $time, what);
		end else begin
			got.keycode = report_keycode;
			got.isup = report_isup;
			got.modifiers = report_modifiers;
			check_report(got, exp, what);
			@(posedge clk);
			pop <= 1'b1;
			@(posedge clk);
			pop <= 1'b0;
		end
	endtask

	task automatic expect_no_report(string what);
		@(negedge clk);
		check_level(report_valid, 1'b0, what);
	endtask

	`include "kbd_tests.svh"

	initial begin
		reset = 1'b1;
		rx_line = 1'b1;
		matrix_row = '0;
		pop = 1'b0;
		keyboard_block = 1'b0;
		lfsr = 8'd18;
		mismatch_count = 0;
		failure_count = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_level(report_valid, 1'b0, "report_valid after reset");
		check_level(overflow, 1'b0, "overflow after reset");
		check_level(turbo_state, 1'b0, "turbo_state after reset");
		check_level(alpha_state, 1'b0, "alpha_state after reset");
		press_release_keys();
		shift_pairing();
		block_input();
		typematic_repeat();
		turbo_and_alpha();
		fifo_overflow();
		$display("Errors: %0d mismatches, %0d other failures.", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
